//--- common/dac_ctrl_params.svh
`ifndef DAC_CTRL_PARAMS_SVH
`define DAC_CTRL_PARAMS_SVH

//////////////////////////////////////////////////
// DAC word and channel sizes
`define DAC_NUM_CH       8      // Channels on the converter
`define DAC_VAL_W        16     // Offset-binary code width
`define DAC_ABS_W        15     // Magnitude of a signed channel value
`define DAC_CAL_MAX      4096   // Largest allowed calibration magnitude
`define DAC_OFFSET_ZERO  32767  // Offset code that means zero volts

//////////////////////////////////////////////////
// SPI framing
`define SPI_FRAME_BITS      24  // Command, spare bit, channel and code
// Larger of settle time at the SPI rate and the frame length
`define SPI_CS_HIGH_CYCLES  24
`define SPI_CMD_WRITE       4'b0001  // Register write, applied on LDAC

//////////////////////////////////////////////////
// Command word fields
`define DELAY_W  26  // Delay count in clocks

`endif

//--- common/dac_ctrl_pkg.sv
`include "dac_ctrl_params.svh"

package dac_ctrl_pkg;

  localparam int CH_W = $clog2(`DAC_NUM_CH);  // Channel index width

  // Opcode in the top two bits of every command word
  typedef enum logic [1:0] {
    CMD_NO_OP   = 2'b00,  // Wait on delay or trigger
    CMD_DAC_WR  = 2'b01,  // Four pair words follow
    CMD_SET_CAL = 2'b10,
    CMD_CANCEL  = 2'b11   // Drop a pending wait, no LDAC
  } cmd_op_e;

  // Header view for no-op and DAC write
  typedef struct packed {
    cmd_op_e             op;
    logic                trig;   // Wait for trigger instead of delay
    logic                cont;   // Another command must follow
    logic                ldac;   // Pulse LDAC when the wait ends
    logic                spare;
    logic [`DELAY_W-1:0] delay;
  } cmd_hdr_t;

  // Set-cal view
  typedef struct packed {
    cmd_op_e                      op;
    logic [10:0]                  spare;
    logic [CH_W-1:0]              ch;
    logic signed [`DAC_VAL_W-1:0] val;
  } cal_cmd_t;

  // Value pair view, odd channel in the upper half
  typedef struct packed {
    logic [`DAC_VAL_W-1:0] odd_code;
    logic [`DAC_VAL_W-1:0] even_code;
  } pair_word_t;

  // One FIFO word, decoded by what the sequencer expects next
  typedef union packed {
    cmd_hdr_t   hdr;
    cal_cmd_t   cal;
    pair_word_t pair;
  } cmd_word_u;

  // Calibration load from sequencer to value path
  typedef struct packed {
    logic                         valid;
    logic [CH_W-1:0]              ch;
    logic signed [`DAC_VAL_W-1:0] val;
  } cal_write_t;

  // Calibrated pair from value path to SPI transmitter
  typedef struct packed {
    logic [CH_W-1:0]       ch;         // Even channel of the pair
    logic [`DAC_VAL_W-1:0] even_code;
    logic [`DAC_VAL_W-1:0] odd_code;
  } frame_pair_t;

  // Channel 0 in the low bits
  typedef logic [`DAC_NUM_CH-1:0][`DAC_ABS_W-1:0] abs_vals_t;

endpackage

//--- sequencer/cmd_sequencer.sv
`timescale 1ns/10ps
`include "dac_ctrl_params.svh"

module cmd_sequencer
  import dac_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       resetn,
  input  cmd_word_u  cmd_word,
  input  logic       cmd_empty,
  output logic       cmd_rd_en,
  input  logic       trigger,
  input  logic       ldac_shared,
  input  logic       fault,
  input  logic       pair_ready,
  output logic       pair_pop,
  output cal_write_t cal_wr,
  input  logic       write_done,
  output logic       waiting_for_trig,
  output logic       ldac,
  output logic       cmd_underflow,
  output logic       unexp_trig
);

  localparam int PAIR_W = $clog2(`DAC_NUM_CH / 2) + 1;  // Holds the full pair count

  typedef enum logic [2:0] {
    S_IDLE,    // Ready for the next command
    S_DELAY,   // Delay timer running
    S_TRIG,    // Waiting on trigger
    S_DAC_WR,  // Pair words and SPI frames in progress
    S_ERROR    // Locked until reset
  } seq_state_e;

  seq_state_e          state;
  cmd_hdr_t            hdr;
  logic                do_ldac;       // Latched command bits
  logic                wait_trig;
  logic                expect_next;
  logic [`DELAY_W-1:0] delay_timer;
  logic [PAIR_W-1:0]   pairs_left;
  logic                in_wait;
  logic                wait_end;
  logic                cancel_seen;
  logic                trig_err;
  logic                shared_err;
  logic                under_now;
  logic                halt;
  logic                idle_pop;

  assign hdr     = cmd_word.hdr;
  assign in_wait = (state == S_DELAY) || (state == S_TRIG);

  //////////////////////////////////////////////////
  // Wait handling and error detection
  assign wait_end    = ((state == S_DELAY) && (delay_timer <= 1))
                       || ((state == S_TRIG) && trigger);
  assign cancel_seen = in_wait && !cmd_empty && (hdr.op == CMD_CANCEL);
  assign trig_err    = trigger && (state != S_TRIG);
  assign shared_err  = ldac_shared && (state == S_DAC_WR);  // Someone else loading mid write
  // Pair needed, or cont promised another command
  assign under_now   = cmd_empty
                       && (((state == S_DAC_WR) && (pairs_left != '0) && pair_ready)
                           || (wait_end && !cancel_seen && expect_next));
  assign halt        = (state == S_ERROR) || fault || trig_err || shared_err || under_now;

  //////////////////////////////////////////////////
  // FIFO pops
  assign idle_pop  = (state == S_IDLE) && !cmd_empty && !halt;
  assign pair_pop  = (state == S_DAC_WR) && (pairs_left != '0) && pair_ready
                     && !cmd_empty && !halt;  // Stalls while value path is busy
  assign cmd_rd_en = idle_pop || pair_pop || (cancel_seen && !halt);

  assign cal_wr = '{valid: idle_pop && (hdr.op == CMD_SET_CAL),
                    ch:    cmd_word.cal.ch,
                    val:   cmd_word.cal.val};

  assign waiting_for_trig = (state == S_TRIG);

  // Main FSM
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= S_IDLE;
    end else if (halt) begin
      state <= S_ERROR;
    end else begin
      case (state)
        S_IDLE: begin
          if (idle_pop && (hdr.op == CMD_NO_OP)) begin
            state <= hdr.trig ? S_TRIG : S_DELAY;  // Wait starts at the pop
          end else if (idle_pop && (hdr.op == CMD_DAC_WR)) begin
            state <= S_DAC_WR;
          end
        end
        S_DAC_WR: if (write_done) state <= wait_trig ? S_TRIG : S_DELAY;
        S_DELAY,
        S_TRIG:   if (cancel_seen || wait_end) state <= S_IDLE;
        default:  state <= S_ERROR;
      endcase
    end
  end

  // Latched header bits, delay timer and pair count
  always_ff @(posedge clk) begin
    if (!resetn) begin
      do_ldac     <= 1'b0;
      wait_trig   <= 1'b0;
      expect_next <= 1'b0;
      delay_timer <= '0;
      pairs_left  <= '0;
    end else if (idle_pop && ((hdr.op == CMD_NO_OP) || (hdr.op == CMD_DAC_WR))) begin
      do_ldac     <= hdr.ldac;
      wait_trig   <= hdr.trig;
      expect_next <= hdr.cont;
      delay_timer <= hdr.delay;  // Held through the SPI writes
      pairs_left  <= (hdr.op == CMD_DAC_WR) ? PAIR_W'(`DAC_NUM_CH / 2) : '0;
    end else begin
      if ((state == S_DELAY) && (delay_timer != '0)) delay_timer <= delay_timer - 1'b1;
      if (pair_pop) pairs_left <= pairs_left - 1'b1;
    end
  end

  // LDAC one clock after the wait ends
  always_ff @(posedge clk) begin
    if (!resetn) begin
      ldac <= 1'b0;
    end else begin
      ldac <= wait_end && do_ldac && !cancel_seen && !halt;
    end
  end

  // Sticky flags, first cause only
  always_ff @(posedge clk) begin
    if (!resetn) begin
      unexp_trig    <= 1'b0;
      cmd_underflow <= 1'b0;
    end else if (state != S_ERROR) begin
      if (trig_err || shared_err) unexp_trig <= 1'b1;
      if (under_now) cmd_underflow <= 1'b1;
    end
  end

endmodule

//--- value_path/dac_value_path.sv
`timescale 1ns/10ps
`include "dac_ctrl_params.svh"

module dac_value_path
  import dac_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        resetn,
  input  cmd_word_u   cmd_word,
  input  logic        pair_pop,
  output logic        pair_ready,
  input  cal_write_t  cal_wr,
  input  logic        ldac,
  output frame_pair_t frame_out,
  output logic        frame_valid,
  input  logic        frame_ready,
  output logic        cal_oob,
  output logic        dac_val_oob,
  output abs_vals_t   abs_dac_vals
);

  localparam int SUM_W = `DAC_VAL_W + 1;  // Room for calibration overshoot
  localparam logic signed [SUM_W-1:0]      ZERO_CODE = SUM_W'(`DAC_OFFSET_ZERO);
  localparam logic signed [`DAC_VAL_W-1:0] CAL_MAX   = `DAC_VAL_W'(`DAC_CAL_MAX);

  logic signed [`DAC_VAL_W-1:0] cal_tab [`DAC_NUM_CH];  // Per-channel signed offset
  logic [`DAC_ABS_W-1:0]        abs_tab [`DAC_NUM_CH];  // Magnitudes before LDAC
  logic [CH_W-2:0]              pair_cnt;                // Which pair comes next
  logic                         busy;                    // Pair popped, not yet handed on
  logic                         s1_valid;
  logic [CH_W-1:0]              s1_ch;
  logic [CH_W-1:0]              s1_odd_ch;
  logic signed [SUM_W-1:0]      s1_even;
  logic signed [SUM_W-1:0]      s1_odd;
  logic signed [SUM_W-1:0]      sum_even;
  logic signed [SUM_W-1:0]      sum_odd;
  logic                         raw_bad;
  logic                         sum_bad;
  logic                         cal_bad;

  function automatic logic signed [SUM_W-1:0] to_signed(input logic [`DAC_VAL_W-1:0] code);
    return $signed({1'b0, code}) - ZERO_CODE;
  endfunction

  function automatic logic out_of_range(input logic signed [SUM_W-1:0] v);
    return (v > ZERO_CODE) || (v < -ZERO_CODE);
  endfunction

  function automatic logic [`DAC_ABS_W-1:0] magnitude(input logic signed [SUM_W-1:0] v);
    logic signed [SUM_W-1:0] m;
    m = (v < 0) ? -v : v;
    return m[`DAC_ABS_W-1:0];
  endfunction

  assign pair_ready = !busy;
  assign s1_odd_ch  = {s1_ch[CH_W-1:1], 1'b1};
  assign sum_even   = s1_even + cal_tab[s1_ch];
  assign sum_odd    = s1_odd + cal_tab[s1_odd_ch];
  assign raw_bad    = pair_pop && ((cmd_word.pair.even_code == '1)
                                   || (cmd_word.pair.odd_code == '1));  // FFFF not allowed
  assign sum_bad    = s1_valid && (out_of_range(sum_even) || out_of_range(sum_odd));
  assign cal_bad    = (cal_wr.val > CAL_MAX) || (cal_wr.val < -CAL_MAX);

  //////////////////////////////////////////////////
  // Calibration table
  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < `DAC_NUM_CH; i++) cal_tab[i] <= '0;
      cal_oob <= 1'b0;
    end else if (cal_wr.valid) begin
      if (cal_bad) cal_oob <= 1'b1;  // Table left as it was
      else cal_tab[cal_wr.ch] <= cal_wr.val;
    end
  end

  //////////////////////////////////////////////////
  // Pipeline control
  always_ff @(posedge clk) begin
    if (!resetn) begin
      pair_cnt    <= '0;
      busy        <= 1'b0;
      s1_valid    <= 1'b0;
      frame_valid <= 1'b0;
      dac_val_oob <= 1'b0;
    end else begin
      s1_valid <= pair_pop && !raw_bad;
      if (pair_pop) begin
        pair_cnt <= pair_cnt + 1'b1;  // Wraps after channel 6/7
        busy     <= 1'b1;
      end else if (frame_valid && frame_ready) begin
        busy <= 1'b0;
      end
      if (s1_valid && !sum_bad) frame_valid <= 1'b1;
      else if (frame_ready) frame_valid <= 1'b0;
      if (raw_bad || sum_bad) dac_val_oob <= 1'b1;  // A bad pair never leaves
    end
  end

  // Stage 1 offset to signed, stage 2 calibrated codes
  always_ff @(posedge clk) begin
    if (pair_pop) begin
      s1_ch   <= {pair_cnt, 1'b0};
      s1_even <= to_signed(cmd_word.pair.even_code);
      s1_odd  <= to_signed(cmd_word.pair.odd_code);
    end
    if (s1_valid) begin
      frame_out.ch        <= s1_ch;
      frame_out.even_code <= `DAC_VAL_W'(sum_even + ZERO_CODE);
      frame_out.odd_code  <= `DAC_VAL_W'(sum_odd + ZERO_CODE);
    end
  end

  //////////////////////////////////////////////////
  // Absolute values, published on LDAC
  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < `DAC_NUM_CH; i++) abs_tab[i] <= '0;
      abs_dac_vals <= '0;
    end else begin
      if (s1_valid && !sum_bad) begin
        abs_tab[s1_ch]     <= magnitude(sum_even);
        abs_tab[s1_odd_ch] <= magnitude(sum_odd);
      end
      if (ldac) begin
        for (int i = 0; i < `DAC_NUM_CH; i++) abs_dac_vals[i] <= abs_tab[i];
      end
    end
  end

endmodule

//--- source/spi_frame_tx.sv
`timescale 1ns/10ps
`include "dac_ctrl_params.svh"

module spi_frame_tx
  import dac_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        resetn,
  input  frame_pair_t frame_in,
  input  logic        frame_valid,
  output logic        frame_ready,
  output logic        n_cs,
  output logic        mosi,
  output logic        write_done
);

  localparam int SPAN  = (`SPI_CS_HIGH_CYCLES > `SPI_FRAME_BITS) ?
                         `SPI_CS_HIGH_CYCLES : `SPI_FRAME_BITS;
  localparam int CNT_W = $clog2(SPAN);

  typedef enum logic [1:0] {
    PH_IDLE,   // Nothing to send
    PH_GAP,    // n_cs high before a frame
    PH_SHIFT   // n_cs low, one bit per clock
  } tx_phase_e;

  tx_phase_e                  phase;
  logic [CNT_W-1:0]           cnt;        // Gap or bit countdown
  frame_pair_t                hold;       // Next pair, waiting its turn
  logic                       hold_valid;
  logic                       odd_valid;  // Odd half of the current pair still to go
  logic [CH_W-1:0]            odd_ch;
  logic [`DAC_VAL_W-1:0]      odd_code;
  logic [CH_W-1:0]            cur_ch;     // Channel of the frame on the wire
  logic [`SPI_FRAME_BITS-1:0] shreg;
  logic                       frame_end;
  logic                       load;

  function automatic logic [`SPI_FRAME_BITS-1:0] build_frame(input logic [CH_W-1:0] ch,
                                                             input logic [`DAC_VAL_W-1:0] code);
    return {`SPI_CMD_WRITE, 1'b0, ch, code};
  endfunction

  assign frame_ready = !hold_valid;
  assign frame_end   = (phase == PH_SHIFT) && (cnt == '0);
  assign load        = ((phase == PH_IDLE) || frame_end) && (odd_valid || hold_valid);
  assign mosi        = shreg[`SPI_FRAME_BITS-1];  // MSB first

  //////////////////////////////////////////////////
  // Chip select timing and shifter
  always_ff @(posedge clk) begin
    if (!resetn) begin
      phase      <= PH_IDLE;
      cnt        <= '0;
      n_cs       <= 1'b1;
      hold_valid <= 1'b0;
      odd_valid  <= 1'b0;
      write_done <= 1'b0;
      shreg      <= '0;
    end else begin
      write_done <= frame_end && (cur_ch == CH_W'(`DAC_NUM_CH - 1));
      if (frame_valid && frame_ready) hold_valid <= 1'b1;
      if (load) begin
        phase <= PH_GAP;
        cnt   <= CNT_W'(`SPI_CS_HIGH_CYCLES - 1);
        n_cs  <= 1'b1;
        if (odd_valid) begin
          shreg     <= build_frame(odd_ch, odd_code);
          odd_valid <= 1'b0;
        end else begin
          shreg      <= build_frame(hold.ch, hold.even_code);  // Even channel goes first
          odd_valid  <= 1'b1;
          hold_valid <= 1'b0;  // Buffer free for the next pair
        end
      end else begin
        case (phase)
          PH_GAP: begin
            if (cnt == '0) begin
              phase <= PH_SHIFT;
              cnt   <= CNT_W'(`SPI_FRAME_BITS - 1);
              n_cs  <= 1'b0;
            end else begin
              cnt <= cnt - 1'b1;
            end
          end
          PH_SHIFT: begin
            shreg <= {shreg[`SPI_FRAME_BITS-2:0], 1'b0};
            if (cnt == '0) begin
              phase <= PH_IDLE;
              n_cs  <= 1'b1;
            end else begin
              cnt <= cnt - 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Pair payload
  always_ff @(posedge clk) begin
    if (frame_valid && frame_ready) hold <= frame_in;
    if (load && odd_valid) begin
      cur_ch <= odd_ch;
    end else if (load) begin
      cur_ch   <= hold.ch;
      odd_ch   <= {hold.ch[CH_W-1:1], 1'b1};
      odd_code <= hold.odd_code;
    end
  end

endmodule

//--- source/dac_ctrl_top.sv
`timescale 1ns/10ps
`include "dac_ctrl_params.svh"

module dac_ctrl_top
  import dac_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      resetn,
  // Command FIFO, first word falls through
  input  cmd_word_u cmd_word,
  input  logic      cmd_empty,
  output logic      cmd_rd_en,
  // Trigger and shared LDAC
  input  logic      trigger,
  input  logic      ldac_shared,
  output logic      waiting_for_trig,
  // Sticky error flags
  output logic      cmd_underflow,
  output logic      unexp_trig,
  output logic      cal_oob,
  output logic      dac_val_oob,
  output abs_vals_t abs_dac_vals,
  // DAC pins
  output logic      n_cs,
  output logic      mosi,
  output logic      ldac
);

  logic        pair_ready;   // Value path can take a pair word
  logic        pair_pop;
  logic        write_done;   // Channel 7 frame finished
  logic        frame_valid;
  logic        frame_ready;
  cal_write_t  cal_wr;
  frame_pair_t frame;

  // Timing and command decode
  cmd_sequencer u_seq (
    .clk              (clk),
    .resetn           (resetn),
    .cmd_word         (cmd_word),
    .cmd_empty        (cmd_empty),
    .cmd_rd_en        (cmd_rd_en),
    .trigger          (trigger),
    .ldac_shared      (ldac_shared),
    .fault            (cal_oob || dac_val_oob),  // Value path errors lock the FSM
    .pair_ready       (pair_ready),
    .pair_pop         (pair_pop),
    .cal_wr           (cal_wr),
    .write_done       (write_done),
    .waiting_for_trig (waiting_for_trig),
    .ldac             (ldac),
    .cmd_underflow    (cmd_underflow),
    .unexp_trig       (unexp_trig)
  );

  // Calibration and conversion
  dac_value_path u_vp (
    .clk          (clk),
    .resetn       (resetn),
    .cmd_word     (cmd_word),
    .pair_pop     (pair_pop),
    .pair_ready   (pair_ready),
    .cal_wr       (cal_wr),
    .ldac         (ldac),
    .frame_out    (frame),
    .frame_valid  (frame_valid),
    .frame_ready  (frame_ready),
    .cal_oob      (cal_oob),
    .dac_val_oob  (dac_val_oob),
    .abs_dac_vals (abs_dac_vals)
  );

  // SPI output
  spi_frame_tx u_tx (
    .clk         (clk),
    .resetn      (resetn),
    .frame_in    (frame),
    .frame_valid (frame_valid),
    .frame_ready (frame_ready),
    .n_cs        (n_cs),
    .mosi        (mosi),
    .write_done  (write_done)
  );

endmodule

//--- test/dac_ctrl_tb.sv
`timescale 1ns/10ps
`include "dac_ctrl_params.svh"

module dac_ctrl_tb
  import dac_ctrl_pkg::*;
();

  localparam int EV_FRAMES     = 0;  // Wait targets for wait_until
  localparam int EV_LDAC       = 1;
  localparam int EV_TRIG_WAIT  = 2;
  localparam int EV_CAL_OOB    = 3;
  localparam int EV_VAL_OOB    = 4;
  localparam int EV_UNDERFLOW  = 5;
  localparam int EV_UNEXP_TRIG = 6;
  localparam int EV_FIFO_EMPTY = 7;

  logic      clk;
  logic      resetn;
  cmd_word_u cmd_word;
  logic      cmd_empty;
  logic      cmd_rd_en;
  logic      trigger;
  logic      ldac_shared;
  logic      waiting_for_trig;
  logic      cmd_underflow;
  logic      unexp_trig;
  logic      cal_oob;
  logic      dac_val_oob;
  abs_vals_t abs_dac_vals;
  logic      n_cs;
  logic      mosi;
  logic      ldac;

  logic [31:0]                fifo_q[$];  // Command FIFO model, head drives cmd_word
  logic [`SPI_FRAME_BITS-1:0] frames[$];  // Decoded SPI frames in arrival order
  logic [`SPI_FRAME_BITS-1:0] shift_in;
  logic                       popped;
  int bit_cnt;
  int gap_cnt;       // Cycles n_cs has been high
  int ldac_count;    // Cycles ldac seen high
  int pop_count;
  int errors;
  int err_mark;
  int tests_run;
  int tests_failed;
  int raw[`DAC_NUM_CH];  // Offset codes sent per channel
  int cal[`DAC_NUM_CH];  // Calibration loaded per channel
  int pops_before;

  dac_ctrl_top i_dut (
    .clk              (clk),
    .resetn           (resetn),
    .cmd_word         (cmd_word),
    .cmd_empty        (cmd_empty),
    .cmd_rd_en        (cmd_rd_en),
    .trigger          (trigger),
    .ldac_shared      (ldac_shared),
    .waiting_for_trig (waiting_for_trig),
    .cmd_underflow    (cmd_underflow),
    .unexp_trig       (unexp_trig),
    .cal_oob          (cal_oob),
    .dac_val_oob      (dac_val_oob),
    .abs_dac_vals     (abs_dac_vals),
    .n_cs             (n_cs),
    .mosi             (mosi),
    .ldac             (ldac)
  );

  always #5 clk = ~clk;  // 10 ns period

  //////////////////////////////////////////////////
  // Reference model and word builders
  function automatic logic [15:0] ref_code(input int code, input int cal_v);
    int s;
    s = code - `DAC_OFFSET_ZERO + cal_v;  // Signed channel value
    return 16'(s + `DAC_OFFSET_ZERO);
  endfunction

  function automatic int ref_abs(input int code, input int cal_v);
    int s;
    s = code - `DAC_OFFSET_ZERO + cal_v;
    return (s < 0) ? -s : s;
  endfunction

  function automatic logic [31:0] hdr_word(input logic [1:0] op, input logic trig,
                                           input logic cont, input logic ld, input int delay);
    return {op, trig, cont, ld, 1'b0, `DELAY_W'(delay)};
  endfunction

  function automatic logic [31:0] cal_word(input int ch, input int val);
    return {2'b10, 11'b0, 3'(ch), 16'(val)};
  endfunction

  //////////////////////////////////////////////////
  // Checks
  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic expect_true(input string what, input bit cond);
    assert (cond) else begin
      $display("Check failed %s", what);
      errors++;
    end
  endtask

  task automatic check_flags(input bit u, input bit t, input bit c, input bit v);
    expect_equal("cmd_underflow", 32'(cmd_underflow), 32'(u));
    expect_equal("unexp_trig", 32'(unexp_trig), 32'(t));
    expect_equal("cal_oob", 32'(cal_oob), 32'(c));
    expect_equal("dac_val_oob", 32'(dac_val_oob), 32'(v));
  endtask

  task automatic check_frames();
    expect_equal("frame count", 32'(frames.size()), 32'(`DAC_NUM_CH));
    for (int i = 0; (i < frames.size()) && (i < `DAC_NUM_CH); i++) begin
      expect_equal($sformatf("mosi frame %0d", i), 32'(frames[i]),
                   {8'h00, `SPI_CMD_WRITE, 1'b0, 3'(i), ref_code(raw[i], cal[i])});
    end
  endtask

  task automatic check_abs();
    for (int i = 0; i < `DAC_NUM_CH; i++) begin
      expect_equal($sformatf("abs_dac_vals[%0d]", i), 32'(abs_dac_vals[i]),
                   32'(ref_abs(raw[i], cal[i])));
    end
  endtask

  // Nothing published since reset
  task automatic check_abs_cleared();
    for (int i = 0; i < `DAC_NUM_CH; i++) begin
      expect_equal($sformatf("abs_dac_vals[%0d]", i), 32'(abs_dac_vals[i]), 32'd0);
    end
  endtask

  //////////////////////////////////////////////////
  // FIFO model, SPI capture and clocking
  task automatic drive_fifo();
    cmd_empty = (fifo_q.size() == 0);
    if (fifo_q.size() > 0) cmd_word = fifo_q[0];
    else cmd_word = '0;
  endtask

  task automatic push_word(input logic [31:0] w);
    fifo_q.push_back(w);
    drive_fifo();
  endtask

  task automatic capture_spi();
    if (!n_cs) begin
      if (bit_cnt == 0) begin
        expect_true("n_cs was high too briefly before a frame",
                    gap_cnt >= `SPI_CS_HIGH_CYCLES);
      end
      shift_in = {shift_in[`SPI_FRAME_BITS-2:0], mosi};  // MSB arrives first
      bit_cnt++;
      gap_cnt = 0;
      if (bit_cnt == `SPI_FRAME_BITS) begin
        frames.push_back(shift_in);
        bit_cnt = 0;
      end
    end else begin
      expect_true("n_cs rose in the middle of a frame", bit_cnt == 0);
      bit_cnt = 0;
      gap_cnt++;
    end
  endtask

  // One clock, pop seen at the rising edge, inputs updated on the falling edge
  task automatic step();
    @(posedge clk);
    popped = cmd_rd_en;
    @(negedge clk);
    if (popped) begin
      expect_true("cmd_rd_en popped an empty command FIFO", fifo_q.size() > 0);
      if (fifo_q.size() > 0) void'(fifo_q.pop_front());
      pop_count++;
    end
    if (ldac) ldac_count++;
    capture_spi();
    drive_fifo();
  endtask

  function automatic bit event_seen(input int kind);
    case (kind)
      EV_FRAMES:     return frames.size() >= `DAC_NUM_CH;
      EV_LDAC:       return ldac_count > 0;
      EV_TRIG_WAIT:  return waiting_for_trig === 1'b1;
      EV_CAL_OOB:    return cal_oob === 1'b1;
      EV_VAL_OOB:    return dac_val_oob === 1'b1;
      EV_UNDERFLOW:  return cmd_underflow === 1'b1;
      EV_UNEXP_TRIG: return unexp_trig === 1'b1;
      default:       return fifo_q.size() == 0;
    endcase
  endfunction

  task automatic wait_until(input int kind, input string what, input int limit);
    int n;
    n = 0;
    while (!event_seen(kind) && (n < limit)) begin
      step();
      n++;
    end
    if (!event_seen(kind)) begin
      $display("Timed out after %0d cycles waiting for %s", limit, what);
      errors++;
    end
  endtask

  task automatic apply_reset();
    resetn      = 1'b0;
    trigger     = 1'b0;
    ldac_shared = 1'b0;
    fifo_q.delete();
    frames.delete();
    bit_cnt    = 0;
    gap_cnt    = 0;
    ldac_count = 0;
    pop_count  = 0;
    for (int i = 0; i < `DAC_NUM_CH; i++) cal[i] = 0;
    drive_fifo();
    repeat (4) step();
    resetn = 1'b1;
  endtask

  // Header plus the first npairs pair words, odd channel in the upper half
  task automatic send_dac_write(input logic trig, input logic ld, input int delay,
                                input int npairs);
    push_word(hdr_word(2'b01, trig, 1'b0, ld, delay));
    for (int k = 0; k < npairs; k++) push_word({16'(raw[2*k+1]), 16'(raw[2*k])});
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %s ok", name);
    end else begin
      $display("test %s had %0d errors", name, errors - err_mark);
      tests_failed++;
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  initial begin
    void'($urandom(30245));
    clk          = 1'b0;
    resetn       = 1'b0;
    trigger      = 1'b0;
    ldac_shared  = 1'b0;
    cmd_empty    = 1'b1;
    cmd_word     = '0;
    popped       = 1'b0;
    shift_in     = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;

    // Plain DAC write, zero calibration
    err_mark = errors;
    apply_reset();
    for (int i = 0; i < `DAC_NUM_CH; i++) raw[i] = int'($urandom_range(16'hFFFE, 0));
    send_dac_write(1'b0, 1'b1, 5, 4);
    wait_until(EV_FRAMES, "eight SPI frames", 1500);
    wait_until(EV_LDAC, "ldac after the delay", 200);
    check_abs_cleared();  // Still the reset values during the ldac clock
    check_frames();
    step();  // abs_dac_vals follows ldac by a clock
    check_abs();
    repeat (5) step();
    expect_equal("ldac high cycles", 32'(ldac_count), 32'd1);
    check_flags(1'b0, 1'b0, 1'b0, 1'b0);
    end_test("1 dac write");

    // Calibrated DAC write
    err_mark = errors;
    apply_reset();
    for (int i = 0; i < `DAC_NUM_CH; i++) begin
      cal[i] = int'($urandom_range(8192, 0)) - `DAC_CAL_MAX;
      push_word(cal_word(i, cal[i]));
      raw[i] = int'($urandom_range(60000, 5000));  // Sum stays inside the code range
    end
    send_dac_write(1'b0, 1'b1, 3, 4);
    wait_until(EV_FRAMES, "eight SPI frames", 1500);
    wait_until(EV_LDAC, "ldac after the delay", 200);
    check_frames();
    step();
    check_abs();
    check_flags(1'b0, 1'b0, 1'b0, 1'b0);
    end_test("2 calibration");

    // Trigger wait, then delay ended by cancel
    err_mark = errors;
    apply_reset();
    push_word(hdr_word(2'b00, 1'b1, 1'b0, 1'b1, 0));
    wait_until(EV_TRIG_WAIT, "waiting_for_trig", 20);
    expect_equal("ldac before trigger", 32'(ldac_count), 32'd0);
    trigger = 1'b1;
    step();
    trigger = 1'b0;
    expect_equal("ldac", 32'(ldac), 32'd1);  // Clock after the trigger
    repeat (10) step();
    expect_equal("ldac high cycles", 32'(ldac_count), 32'd1);
    expect_equal("waiting_for_trig", 32'(waiting_for_trig), 32'd0);
    ldac_count = 0;
    push_word(hdr_word(2'b00, 1'b0, 1'b0, 1'b1, 200));
    push_word({2'b11, 30'b0});  // Cancel
    wait_until(EV_FIFO_EMPTY, "both words popped", 20);
    repeat (300) step();
    expect_equal("ldac high cycles after cancel", 32'(ldac_count), 32'd0);
    check_flags(1'b0, 1'b0, 1'b0, 1'b0);
    end_test("3 trigger and cancel");

    // Stray trigger locks the controller
    err_mark = errors;
    apply_reset();
    step();
    trigger = 1'b1;
    step();
    trigger = 1'b0;
    wait_until(EV_UNEXP_TRIG, "unexp_trig", 10);
    for (int i = 0; i < `DAC_NUM_CH; i++) raw[i] = int'($urandom_range(16'hFFFE, 0));
    pops_before = pop_count;
    send_dac_write(1'b0, 1'b1, 4, 4);
    repeat (300) step();
    expect_equal("pops in error state", 32'(pop_count - pops_before), 32'd0);
    expect_equal("frames in error state", 32'(frames.size()), 32'd0);
    expect_equal("ldac high cycles", 32'(ldac_count), 32'd0);
    expect_equal("n_cs", 32'(n_cs), 32'd1);
    check_flags(1'b0, 1'b1, 1'b0, 1'b0);
    end_test("4 unexpected trigger");

    // Calibration out of bounds
    err_mark = errors;
    apply_reset();
    push_word(cal_word(2, 5000));
    wait_until(EV_CAL_OOB, "cal_oob", 20);
    repeat (20) step();
    check_flags(1'b0, 1'b0, 1'b1, 1'b0);
    end_test("5a cal bounds");

    // Raw code FFFF
    err_mark = errors;
    apply_reset();
    for (int i = 0; i < `DAC_NUM_CH; i++) raw[i] = int'($urandom_range(16'hFFFE, 0));
    raw[3] = 16'hFFFF;
    send_dac_write(1'b0, 1'b0, 4, 4);
    wait_until(EV_VAL_OOB, "dac_val_oob", 200);
    repeat (20) step();
    check_flags(1'b0, 1'b0, 1'b0, 1'b1);
    end_test("5b value bounds");

    // Two pair words short
    err_mark = errors;
    apply_reset();
    for (int i = 0; i < `DAC_NUM_CH; i++) raw[i] = int'($urandom_range(16'hFFFE, 0));
    send_dac_write(1'b0, 1'b0, 4, 2);
    wait_until(EV_UNDERFLOW, "cmd_underflow", 500);
    repeat (20) step();
    check_flags(1'b1, 1'b0, 1'b0, 1'b0);
    end_test("5c underflow");

    // Empty FIFO after reset
    err_mark = errors;
    apply_reset();
    expect_equal("mosi", 32'(mosi), 32'd0);
    check_abs_cleared();
    for (int n = 0; n < 100; n++) begin
      expect_equal("cmd_rd_en", 32'(cmd_rd_en), 32'd0);
      expect_equal("ldac", 32'(ldac), 32'd0);
      expect_equal("n_cs", 32'(n_cs), 32'd1);
      expect_equal("waiting_for_trig", 32'(waiting_for_trig), 32'd0);
      check_flags(1'b0, 1'b0, 1'b0, 1'b0);
      step();
    end
    end_test("6 idle");

    $display("tests run %0d, tests with errors %0d, errors %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+common
common/dac_ctrl_pkg.sv
sequencer/cmd_sequencer.sv
value_path/dac_value_path.sv
source/spi_frame_tx.sv
source/dac_ctrl_top.sv
test/dac_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the DAC controller testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module dac_ctrl_tb \
  -f files.f \
  -o dac_ctrl_sim

./obj_dir/dac_ctrl_sim | tee sim.log

if grep -q "sim failed" sim.log; then
  exit 1
fi
exit 0
